// File: dv/edge_job_tb.sv
// Directed testbench for the edge job controller
// Vertex driver, command and memory model, edge collector, watchdog

`timescale 1ns/1ps
`include "edge_job_config.svh"

module edge_job_tb;

	localparam int NUM_TESTS      = 5;
	localparam int EDGES_PER_TEST = 120;
	localparam int TIMEOUT_CYCLES = NUM_TESTS * EDGES_PER_TEST * 50;

	typedef struct packed {
		logic [`ADDR_BITS-1:0] addr;
		logic [1:0]            op;
		edge_job_pkg::slot_t   first;
		edge_job_pkg::count_t  count;
	} cmd_exp_t;

	logic                       clock = 1'b0;
	logic                       rstn;
	logic [`ADDR_BITS-1:0]      edge_base;
	logic                       vertex_valid;
	logic [`VID_BITS-1:0]       vertex_id;
	edge_job_pkg::count_t       vertex_edge_idx;
	edge_job_pkg::count_t       vertex_edge_count;
	logic                       cmd_grant;
	logic                       rd_valid;
	edge_job_pkg::line_t        rd_data;
	logic                       edge_ready;
	logic                       vertex_ready;
	logic                       cmd_valid;
	logic [`ADDR_BITS-1:0]      cmd_addr;
	edge_job_pkg::read_opcode_t cmd_opcode;
	edge_job_pkg::slot_t        cmd_first;
	edge_job_pkg::count_t       cmd_count;
	logic                       edge_valid;
	logic [`VID_BITS-1:0]       edge_src;
	logic [`EDGE_BITS-1:0]      edge_dest;
	edge_job_pkg::count_t       edge_seq;

	integer                    seed = 32'h73fb_b556;
	int                        errors = 0;
	int                        checks = 0;
	int                        cmd_seen = 0;
	int                        edges_seen = 0;
	cmd_exp_t                  exp_cmds[$];
	edge_job_pkg::edge_entry_t exp_edges[$];

	edge_job_control u_edge_job_control (.*);

	always #2 clock = ~clock;

	//////////////////////////////////////////////////
	// Checks and model
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check failed at %0t: %s", $time, what);
		end
	endtask

	function automatic int rand_below(input int n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	// Edge array contents, a hash of the full byte address
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		mem_word = (addr * 32'h9e37_79b1) ^ 32'h1234_5678;
	endfunction

	function automatic edge_job_pkg::line_t read_line(input logic [31:0] addr);
		read_line = '0;
		for (int i = 0; i < `EDGES_PER_LINE; i++)
			read_line[i*`EDGE_BITS +: `EDGE_BITS] = mem_word(addr + i * `EDGE_BYTES);
	endfunction

	// Splits a job into line chunks and queues the expected commands and edges
	task automatic model_vertex(input logic [15:0] vid, input int idx, input int count);
		cmd_exp_t   c;
		logic [31:0] byte_addr;
		int         first;
		int         n;
		int         seq;
		seq = 0;
		while (count > 0) begin
			byte_addr = edge_base + idx * `EDGE_BYTES;
			first = (byte_addr % `LINE_BYTES) / `EDGE_BYTES;
			n = (count < `EDGES_PER_LINE - first) ? count : `EDGES_PER_LINE - first;
			c.addr = byte_addr & ~(`LINE_BYTES - 1);
			c.first = first;
			c.count = n;
			c.op = (first == 0 && n == `EDGES_PER_LINE) ? edge_job_pkg::READ_LINE
				: edge_job_pkg::READ_PARTIAL;
			exp_cmds.push_back(c);
			for (int k = 0; k < n; k++)
				exp_edges.push_back('{src: vid, dest: mem_word(byte_addr + k * `EDGE_BYTES),
					seq: 16'(seq + k)});
			seq += n;
			idx += n;
			count -= n;
		end
	endtask

	//////////////////////////////////////////////////
	// Drivers and monitors
	//////////////////////////////////////////////////

	task automatic send_vertex(input logic [15:0] vid, input int idx, input int count);
		@(posedge clock);
		vertex_valid <= 1'b1;
		vertex_id <= vid;
		vertex_edge_idx <= 16'(idx);
		vertex_edge_count <= 16'(count);
		model_vertex(vid, idx, count);
		do @(negedge clock); while (!vertex_ready);
		@(posedge clock);
		vertex_valid <= 1'b0;
	endtask

	// Checks one command, grants it late and returns its line
	task automatic serve_command();
		cmd_exp_t held;
		cmd_exp_t exp;
		do @(negedge clock); while (!cmd_valid);
		held = {cmd_addr, 2'(cmd_opcode), cmd_first, cmd_count};
		cmd_seen++;
		if (exp_cmds.size() == 0) begin
			check_true(1'b0, "command issued with no chunk left in the model");
		end else begin
			exp = exp_cmds.pop_front();
			check_value("cmd_addr", held.addr, exp.addr);
			check_value("cmd_opcode", held.op, exp.op);
			check_value("cmd_first", held.first, exp.first);
			check_value("cmd_count", held.count, exp.count);
		end
		repeat (rand_below(4)) begin
			@(posedge clock);
			@(negedge clock);
			check_true(cmd_valid && {cmd_addr, 2'(cmd_opcode), cmd_first, cmd_count} == held,
				"command changed or dropped before its grant");
		end
		@(posedge clock);
		cmd_grant <= 1'b1;
		@(posedge clock);
		cmd_grant <= 1'b0;
		repeat (rand_below(3)) @(posedge clock);
		rd_valid <= 1'b1;
		rd_data <= read_line(held.addr);
		@(posedge clock);
		rd_valid <= 1'b0;
	endtask

	task automatic collect_edges();
		edge_job_pkg::edge_entry_t exp;
		forever begin
			@(negedge clock);
			if (edge_valid && edge_ready) begin
				edges_seen++;
				if (exp_edges.size() == 0) begin
					check_true(1'b0, "edge delivered that the model did not expect");
				end else begin
					exp = exp_edges.pop_front();
					check_value("edge_src", edge_src, exp.src);
					check_value("edge_dest", edge_dest, exp.dest);
					check_value("edge_seq", edge_seq, exp.seq);
				end
			end
			@(posedge clock);
			edge_ready <= (rand_below(4) != 0);
		end
	endtask

	task automatic wait_drained();
		do @(negedge clock);
		while (!(vertex_ready && !edge_valid && exp_cmds.size() == 0 && exp_edges.size() == 0));
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		@(negedge clock);
		check_value("vertex_ready", vertex_ready, 1);
		check_value("cmd_valid", cmd_valid, 0);
		check_value("edge_valid", edge_valid, 0);
	endtask

	task automatic test_job(input logic [15:0] vid, input int idx, input int count,
		input int cmds);
		int cmds0;
		int edges0;
		cmds0 = cmd_seen;
		edges0 = edges_seen;
		send_vertex(vid, idx, count);
		wait_drained();
		check_value("command count", cmd_seen - cmds0, cmds);
		check_value("edge count", edges_seen - edges0, count);
	endtask

	task automatic test_zero_degree();
		send_vertex(16'h0c0d, 12, 0);
		repeat (2) @(posedge clock);
		@(negedge clock);
		check_value("vertex_ready", vertex_ready, 1);
		test_job(16'h0c0e, 40, 0, 0);
	endtask

	task automatic test_random_stream();
		int total;
		int edges0;
		int n;
		int v;
		total = 0;
		edges0 = edges_seen;
		for (v = 0; v < 6; v++) begin
			n = rand_below(20);
			total += n;
			send_vertex(16'(rand_below(65536)), rand_below(64), n);
		end
		wait_drained();
		check_value("edge count", edges_seen - edges0, total);
	endtask

	initial begin
		rstn = 1'b0;
		edge_base = 32'h0004_0000;
		vertex_valid = 1'b0;
		vertex_id = '0;
		vertex_edge_idx = '0;
		vertex_edge_count = '0;
		cmd_grant = 1'b0;
		rd_valid = 1'b0;
		rd_data = '0;
		edge_ready = 1'b0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		test_reset_state();
		test_job(16'h0a11, 8, 8, 1);
		test_job(16'h0b22, 5, 10, 2);
		test_zero_degree();
		test_random_stream();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		wait (rstn === 1'b1);
		forever serve_command();
	end

	initial begin
		wait (rstn === 1'b1);
		collect_edges();
	end

	// Watchdog
	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule

// File: rtl/edge_chunk_counter.sv
// Edge chunk counter
// Tracks index and remaining edges, derives line address, slot, size, opcode

`timescale 1ns/1ps
`include "edge_job_config.svh"

module edge_chunk_counter (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [`ADDR_BITS-1:0] edge_base,
	input  edge_job_pkg::count_t  vertex_edge_idx,
	input  edge_job_pkg::count_t  vertex_edge_count,
	edge_slice_if.counter         s
);

	localparam int EDGE_LO = $clog2(`EDGE_BYTES);
	localparam int LINE_LO = $clog2(`LINE_BYTES);

	edge_job_pkg::count_t  edge_idx;
	edge_job_pkg::count_t  remaining;
	logic [`ADDR_BITS-1:0] byte_addr;
	edge_job_pkg::slot_t   first_slot;
	edge_job_pkg::count_t  room;
	edge_job_pkg::count_t  take;

	//////////////////////////////////////////////////
	// Chunk geometry
	//////////////////////////////////////////////////

	assign byte_addr  = edge_base + (`ADDR_BITS'(edge_idx) << EDGE_LO);
	assign first_slot = byte_addr[LINE_LO-1:EDGE_LO];
	assign room       = edge_job_pkg::count_t'(`EDGES_PER_LINE) - edge_job_pkg::count_t'(first_slot);
	// Whatever is left, up to the end of the line
	assign take       = (remaining < room) ? remaining : room;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_idx  <= '0;
			remaining <= '0;
		end else if (s.load) begin
			edge_idx  <= vertex_edge_idx;
			remaining <= vertex_edge_count;
		end else if (s.step) begin
			edge_idx  <= edge_idx + take;
			remaining <= remaining - take;
		end
	end

	always_ff @(posedge clock) begin
		if (s.step) begin
			s.chunk_addr  <= {byte_addr[`ADDR_BITS-1:LINE_LO], {LINE_LO{1'b0}}};
			s.chunk_first <= first_slot;
			s.chunk_count <= take;
			if (first_slot == '0 && take == edge_job_pkg::count_t'(`EDGES_PER_LINE))
				s.chunk_opcode <= edge_job_pkg::READ_LINE;
			else
				s.chunk_opcode <= edge_job_pkg::READ_PARTIAL;
		end
	end

	assign s.done_edges = (remaining == '0);

	// A chunk never runs past the end of its line
	a_chunk_in_line: assert property (@(posedge clock) disable iff (!rstn)
		s.step |=> (edge_job_pkg::count_t'(s.chunk_first) + s.chunk_count
			<= edge_job_pkg::count_t'(`EDGES_PER_LINE)));

endmodule

// File: rtl/edge_fifo.sv
// First-word-fall-through queue of labelled edges

`timescale 1ns/1ps
`include "edge_job_config.svh"

module edge_fifo (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic                      push,
	input  edge_job_pkg::edge_entry_t push_entry,
	input  logic                      pop,
	output logic                      full,
	output logic                      valid,
	output edge_job_pkg::edge_entry_t head
);

	localparam int PTR_BITS = $clog2(`EDGE_FIFO_DEPTH);

	edge_job_pkg::edge_entry_t mem [`EDGE_FIFO_DEPTH];
	logic [PTR_BITS-1:0]       wr_ptr;
	logic [PTR_BITS-1:0]       rd_ptr;
	logic [PTR_BITS:0]         count;
	logic                      do_push;
	logic                      do_pop;

	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
		ptr_inc = (p == PTR_BITS'(`EDGE_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full    = (count == (PTR_BITS+1)'(`EDGE_FIFO_DEPTH));
	assign valid   = (count != '0);
	assign head    = mem[rd_ptr];
	assign do_push = push && !full;
	assign do_pop  = pop && valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + do_push - do_pop;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	a_no_push_full: assert property (@(posedge clock) disable iff (!rstn) push |-> !full);

endmodule

// File: rtl/edge_job_config.svh
// Width, cacheline and queue-depth macros for the edge job controller
// Shared by the package, the slice interface and the RTL

`ifndef EDGE_JOB_CONFIG_SVH
`define EDGE_JOB_CONFIG_SVH

// Edge destination word
`define EDGE_BITS        32
`define EDGE_BYTES       4

// Cacheline geometry
`define EDGES_PER_LINE   8
`define LINE_BYTES       32

// Address, vertex id and edge count widths
`define ADDR_BITS        32
`define VID_BITS         16
`define CNT_BITS         16

// Output queue
`define EDGE_FIFO_DEPTH  16

`endif

// File: rtl/edge_job_control.sv
// Edge job controller top level
// FSM, chunk counter, line shifter and edge queue

`timescale 1ns/1ps
`include "edge_job_config.svh"

module edge_job_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic [`ADDR_BITS-1:0]      edge_base,
	input  logic                       vertex_valid,
	input  logic [`VID_BITS-1:0]       vertex_id,
	input  edge_job_pkg::count_t       vertex_edge_idx,
	input  edge_job_pkg::count_t       vertex_edge_count,
	input  logic                       cmd_grant,
	input  logic                       rd_valid,
	input  edge_job_pkg::line_t        rd_data,
	input  logic                       edge_ready,
	output logic                       vertex_ready,
	output logic                       cmd_valid,
	output logic [`ADDR_BITS-1:0]      cmd_addr,
	output edge_job_pkg::read_opcode_t cmd_opcode,
	output edge_job_pkg::slot_t        cmd_first,
	output edge_job_pkg::count_t       cmd_count,
	output logic                       edge_valid,
	output logic [`VID_BITS-1:0]       edge_src,
	output logic [`EDGE_BITS-1:0]      edge_dest,
	output edge_job_pkg::count_t       edge_seq
);

	edge_slice_if              slice ();
	logic                      push;
	edge_job_pkg::edge_entry_t push_entry;
	logic                      full;
	edge_job_pkg::edge_entry_t head;

	edge_job_fsm u_fsm (.clock, .rstn, .vertex_valid, .cmd_grant, .rd_valid,
		.vertex_ready, .cmd_valid, .s(slice.fsm));

	edge_chunk_counter u_counter (.clock, .rstn, .edge_base, .vertex_edge_idx,
		.vertex_edge_count, .s(slice.counter));

	edge_line_shifter u_shifter (.clock, .rstn, .rd_data, .vertex_id,
		.s(slice.shifter), .push, .push_entry, .full);

	edge_fifo u_fifo (.clock, .rstn, .push, .push_entry, .pop(edge_ready),
		.full, .valid(edge_valid), .head);

	// Command fields only show while a command is pending
	assign cmd_addr   = cmd_valid ? slice.chunk_addr : '0;
	assign cmd_opcode = cmd_valid ? slice.chunk_opcode : edge_job_pkg::READ_LINE;
	assign cmd_first  = cmd_valid ? slice.chunk_first : '0;
	assign cmd_count  = cmd_valid ? slice.chunk_count : '0;

	assign edge_src  = head.src;
	assign edge_dest = head.dest;
	assign edge_seq  = head.seq;

endmodule

// File: rtl/edge_job_fsm.sv
// Controller FSM for vertex jobs
// Sequences vertex accept, chunk step, command issue, data wait and shift

`timescale 1ns/1ps

module edge_job_fsm (
	input  logic             clock,
	input  logic             rstn,
	input  logic             vertex_valid,
	input  logic             cmd_grant,
	input  logic             rd_valid,
	output logic             vertex_ready,
	output logic             cmd_valid,
	edge_slice_if.fsm        s
);

	edge_job_pkg::edge_state_t state;
	edge_job_pkg::edge_state_t state_next;

	//////////////////////////////////////////////////
	// State register
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= edge_job_pkg::IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			edge_job_pkg::IDLE: begin
				if (vertex_valid)
					state_next = edge_job_pkg::LOAD;
			end
			// Counter settles on the new job
			edge_job_pkg::LOAD: begin
				state_next = edge_job_pkg::NEXT;
			end
			edge_job_pkg::NEXT: begin
				if (s.done_edges)
					state_next = edge_job_pkg::IDLE;
				else
					state_next = edge_job_pkg::ISSUE;
			end
			edge_job_pkg::ISSUE: begin
				if (cmd_grant)
					state_next = edge_job_pkg::WAIT_DATA;
			end
			edge_job_pkg::WAIT_DATA: begin
				if (rd_valid)
					state_next = edge_job_pkg::SHIFT;
			end
			edge_job_pkg::SHIFT: begin
				if (s.shift_done)
					state_next = edge_job_pkg::NEXT;
			end
			default: begin
				state_next = edge_job_pkg::IDLE;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Decoded outputs
	//////////////////////////////////////////////////

	assign vertex_ready = (state == edge_job_pkg::IDLE);
	assign cmd_valid    = (state == edge_job_pkg::ISSUE);

	// Job fields are taken on the accept edge itself
	assign s.load        = vertex_ready && vertex_valid;
	assign s.step        = (state == edge_job_pkg::NEXT) && !s.done_edges;
	assign s.shift_start = (state == edge_job_pkg::WAIT_DATA) && rd_valid;

	// Command is held until granted
	a_cmd_held: assert property (@(posedge clock) disable iff (!rstn)
		$fell(cmd_valid) |-> $past(cmd_grant));

	// Only one line outstanding, data only after a grant
	a_rd_in_wait: assert property (@(posedge clock) disable iff (!rstn)
		rd_valid |-> (state == edge_job_pkg::WAIT_DATA));

endmodule

// File: rtl/edge_job_pkg.sv
// Types for the edge job controller
// Controller states, read opcodes, line and slot types, queue entry

`include "edge_job_config.svh"

package edge_job_pkg;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		ISSUE,
		WAIT_DATA,
		SHIFT,
		NEXT
	} edge_state_t;

	// Full line only when the chunk fills all slots from slot 0
	typedef enum logic [1:0] {
		READ_LINE    = 2'd0,
		READ_PARTIAL = 2'd1
	} read_opcode_t;

	typedef logic [`EDGES_PER_LINE*`EDGE_BITS-1:0] line_t;
	typedef logic [$clog2(`EDGES_PER_LINE)-1:0]    slot_t;
	typedef logic [`CNT_BITS-1:0]                  count_t;

	typedef struct packed {
		logic [`VID_BITS-1:0]  src;
		logic [`EDGE_BITS-1:0] dest;
		count_t                seq;
	} edge_entry_t;

endpackage

// File: rtl/edge_line_shifter.sv
// Line shifter
// Captures one read line and pushes the chunk's edges into the edge queue

`timescale 1ns/1ps
`include "edge_job_config.svh"

module edge_line_shifter (
	input  logic                      clock,
	input  logic                      rstn,
	input  edge_job_pkg::line_t       rd_data,
	input  logic [`VID_BITS-1:0]      vertex_id,
	edge_slice_if.shifter             s,
	output logic                      push,
	output edge_job_pkg::edge_entry_t push_entry,
	input  logic                      full
);

	edge_job_pkg::line_t  line_q;
	edge_job_pkg::count_t left;
	edge_job_pkg::count_t seq_cnt;
	logic                 active;
	logic [`VID_BITS-1:0] src_id;

	// Stall while the queue is full
	assign push         = active && !full;
	assign s.shift_done = push && (left == edge_job_pkg::count_t'(1));

	assign push_entry = '{src: src_id, dest: line_q[`EDGE_BITS-1:0], seq: seq_cnt};

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active  <= 1'b0;
			left    <= '0;
			seq_cnt <= '0;
		end else begin
			if (s.shift_start) begin
				active <= 1'b1;
				left   <= s.chunk_count;
			end else if (push) begin
				left <= left - 1'b1;
				if (s.shift_done)
					active <= 1'b0;
			end
			// Sequence numbers run across all chunks of a vertex
			if (s.load)
				seq_cnt <= '0;
			else if (push)
				seq_cnt <= seq_cnt + 1'b1;
		end
	end

	// First wanted edge lands in the low word, then one word per push
	always_ff @(posedge clock) begin
		if (s.shift_start)
			line_q <= rd_data >> (s.chunk_first * `EDGE_BITS);
		else if (push)
			line_q <= line_q >> `EDGE_BITS;
		if (s.load)
			src_id <= vertex_id;
	end

endmodule

// File: rtl/edge_slice_if.sv
// Chunk and shift control between the FSM, chunk counter and line shifter

`timescale 1ns/1ps
`include "edge_job_config.svh"

interface edge_slice_if;

	// FSM controls
	logic load;
	logic step;
	logic shift_start;

	// Current chunk, valid one cycle after load or step
	logic [`ADDR_BITS-1:0]      chunk_addr;
	edge_job_pkg::slot_t        chunk_first;
	edge_job_pkg::count_t       chunk_count;
	edge_job_pkg::read_opcode_t chunk_opcode;
	logic                       done_edges;

	logic shift_done;

	modport fsm (output load, step, shift_start, input done_edges, shift_done);

	modport counter (input load, step,
		output chunk_addr, chunk_first, chunk_count, chunk_opcode, done_edges);

	modport shifter (input load, shift_start, chunk_first, chunk_count, output shift_done);

endinterface

// File: src.f
+incdir+rtl
rtl/edge_job_pkg.sv
rtl/edge_slice_if.sv
rtl/edge_job_fsm.sv
rtl/edge_chunk_counter.sv
rtl/edge_line_shifter.sv
rtl/edge_fifo.sv
rtl/edge_job_control.sv
dv/edge_job_tb.sv
